// File: tb/rename_trace.txt
# W addr data err | R addr data | S cycles
# I slot opcode psrc1 psrc2 pdst free (opcode dec, rest hex; free = vld over preg)
W 11 41 0
W 12 42 0
W 13 43 0
W 00 415944 0
W 01 436054 0
W 02 8ce 0
R 40 000d0007
W 50 0 1
W 04 415944 1
W 20 4 1
W 40 0 1
R 40 000d0007
S 3
I 0 0 41 42 20 40
I 2 2 43 41 00 00
R 40 000d0507
W 20 0 0
R 40 000f0507
I 1 0 60 40 21 40
W 30 0 0
R 40 000d0606
W 15 60 0
W 30 1 0
W 16 61 0
W 00 457b55 0
W 01 478bdc 0
R 40 000d0407
S 2
I 0 1 60 61 22 40
W 20 0 0
I 1 0 62 62 23 40
R 40 000f0707

// File: src.f
+incdir+include
verilog/rename_pkg.sv
verilog/apb_pkg.sv
verilog/isq_line_store.sv
verilog/rename_lane.sv
verilog/issue_select.sv
verilog/rename_top.sv
tb/tb_rename_top.sv

// File: Makefile
TOP = tb_rename_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f src.f

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Regression passed"

lint:
	verilator --lint-only --timing --top-module rename_top -f src.f

clean:
	rm -rf obj_dir

// File: tb/tb_rename_top.sv
// rename issue queue testbench replaying an apb and issue trace against the issue port
`default_nettype none
`timescale 1ns/1ps

`include "rename_params.svh"

module tb_rename_top;

  logic                            clk;
  logic                            rst_n;
  logic                            psel;
  logic                            penable;
  logic                            pwrite;
  apb_pkg::apb_addr_t              paddr;
  apb_pkg::apb_data_t              pwdata;
  apb_pkg::apb_data_t              prdata;
  logic                            pready;
  logic                            pslverr;
  logic                            issue_rdy;
  logic                            issue_vld;
  logic [`SLOT_BITS-1:0]           issue_slot;
  rename_pkg::opcode_e             issue_opcode;
  rename_pkg::map_entry_t          issue_psrc1;
  rename_pkg::map_entry_t          issue_psrc2;
  rename_pkg::preg_t               issue_pdst;
  rename_pkg::free_preg_t          issue_free;

  // cycle budget is set once the trace length is known
  int cycle_cnt;
  int cycle_limit;

  rename_top dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .psel_i         (psel),
    .penable_i      (penable),
    .pwrite_i       (pwrite),
    .paddr_i        (paddr),
    .pwdata_i       (pwdata),
    .prdata_o       (prdata),
    .pready_o       (pready),
    .pslverr_o      (pslverr),
    .issue_rdy_i    (issue_rdy),
    .issue_vld_o    (issue_vld),
    .issue_slot_o   (issue_slot),
    .issue_opcode_o (issue_opcode),
    .issue_psrc1_o  (issue_psrc1),
    .issue_psrc2_o  (issue_psrc2),
    .issue_pdst_o   (issue_pdst),
    .issue_free_o   (issue_free)
  );

  // 100 ns clock
  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // stop a run that never gets to the end of the trace
  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if ((cycle_limit != 0) && (cycle_cnt >= cycle_limit))
    begin
      $display("timeout: issue port never produced expected instruction");
      $display("Regression failed");
      $fatal(1, "cycle limit reached");
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp));
  endtask

  task automatic check_data(input apb_pkg::apb_data_t got, input apb_pkg::apb_data_t exp,
                            input string what);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_slot(input logic [`SLOT_BITS-1:0] got, input logic [`SLOT_BITS-1:0] exp,
                            input string what);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp));
  endtask

  task automatic check_opcode(input rename_pkg::opcode_e got, input rename_pkg::opcode_e exp,
                              input string what);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp));
  endtask

  task automatic check_map_entry(input rename_pkg::map_entry_t got,
                                 input rename_pkg::map_entry_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_preg(input rename_pkg::preg_t got, input rename_pkg::preg_t exp,
                            input string what);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  // every issue field against the instruction the trace predicts
  task automatic compare_issue(input logic [`SLOT_BITS-1:0] slot, input rename_pkg::opcode_e opc,
                               input rename_pkg::map_entry_t ps1,
                               input rename_pkg::map_entry_t ps2,
                               input rename_pkg::preg_t pdst, input logic free_vld,
                               input rename_pkg::preg_t free_idx);
    check_bit(issue_vld, 1'b1, "issue valid");
    check_slot(issue_slot, slot, "issue slot");
    check_opcode(issue_opcode, opc, "issue opcode");
    check_map_entry(issue_psrc1, ps1, "issue psrc1");
    check_map_entry(issue_psrc2, ps2, "issue psrc2");
    check_preg(issue_pdst, pdst, "issue pdst");
    check_bit(issue_free.vld, free_vld, "issue free valid");
    check_preg(issue_free.idx, free_idx, "issue free preg");
  endtask

  //////////////////////////////
  // drivers
  //////////////////////////////
  // random gap of 0 to 2 idle cycles between host operations
  task automatic idle_gap();
    int unsigned n;
    n = $urandom % 3;
    repeat (n) @(posedge clk);
  endtask

  // setup phase followed by access phase with the write landing on the edge that ends access
  task automatic apb_write(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t data,
                           input logic exp_err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    check_bit(pready, 1'b1, "pready in write access");
    check_bit(pslverr, exp_err, $sformatf("pslverr on write to %h", addr));
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t exp);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    check_bit(pready, 1'b1, "pready in read access");
    check_bit(pslverr, 1'b0, "pslverr on read");
    check_data(prdata, exp, $sformatf("prdata from %h", addr));
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // open the sink and wait for valid, then check mid cycle and fire on the next edge
  task automatic expect_issue(input logic [`SLOT_BITS-1:0] slot, input rename_pkg::opcode_e opc,
                              input rename_pkg::map_entry_t ps1,
                              input rename_pkg::map_entry_t ps2,
                              input rename_pkg::preg_t pdst, input logic free_vld,
                              input rename_pkg::preg_t free_idx);
    @(posedge clk);
    #1;
    issue_rdy = 1'b1;
    @(negedge clk);
    while (!issue_vld)
      @(negedge clk);
    compare_issue(slot, opc, ps1, ps2, pdst, free_vld, free_idx);
    @(posedge clk);
    #1;
    issue_rdy = 1'b0;
  endtask

  // sink held off while the expected issue stays on the port
  task automatic hold_stall(input int n, input logic [`SLOT_BITS-1:0] slot,
                            input rename_pkg::opcode_e opc,
                            input rename_pkg::map_entry_t ps1,
                            input rename_pkg::map_entry_t ps2,
                            input rename_pkg::preg_t pdst, input logic free_vld,
                            input rename_pkg::preg_t free_idx);
    issue_rdy = 1'b0;
    repeat (n)
    begin
      @(negedge clk);
      compare_issue(slot, opc, ps1, ps2, pdst, free_vld, free_idx);
    end
  endtask

  //////////////////////////////
  // trace replay
  //////////////////////////////
  initial
  begin
    int                     fd;
    int                     code;
    int                     n_lines;
    int                     n_ops;
    int                     stall_n;
    logic [7:0]             op;
    logic [8*160-1:0]       line_buf;
    apb_pkg::apb_addr_t     t_addr;
    logic [31:0]            t_data;
    logic [31:0]            t_err;
    logic [31:0]            t_slot;
    logic [31:0]            t_opc;
    logic [31:0]            t_ps1;
    logic [31:0]            t_ps2;
    logic [31:0]            t_pdst;
    logic [31:0]            t_free;
    logic [`SLOT_BITS-1:0]  e_slot;
    rename_pkg::opcode_e    e_opc;
    rename_pkg::map_entry_t e_ps1;
    rename_pkg::map_entry_t e_ps2;
    rename_pkg::preg_t      e_pdst;
    logic                   e_free_vld;
    rename_pkg::preg_t      e_free_idx;
    void'($urandom(32'hefaf));
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    issue_rdy   = 1'b0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    n_lines     = 0;
    n_ops       = 0;
    stall_n     = 0;

    // first pass sizes the cycle budget
    fd = $fopen("tb/rename_trace.txt", "r");
    if (fd == 0)
      abort_run("could not open the trace file tb/rename_trace.txt");
    while (!$feof(fd))
    begin
      void'($fgets(line_buf, fd));
      n_lines = n_lines + 1;
    end
    $fclose(fd);
    cycle_limit = 40 * n_lines + 8;

    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_bit(issue_vld, 1'b0, "issue valid after reset");
    check_bit(pready, 1'b0, "pready after reset");
    check_bit(pslverr, 1'b0, "pslverr after reset");

    fd = $fopen("tb/rename_trace.txt", "r");
    while ($fscanf(fd, "%s", op) == 1)
    begin
      case (op)
        "#": void'($fgets(line_buf, fd));
        "W":
        begin
          code = $fscanf(fd, "%h %h %d", t_addr, t_data, t_err);
          if (code != 3)
            abort_run("malformed W line in the trace");
          idle_gap();
          apb_write(t_addr, t_data, t_err[0]);
          n_ops = n_ops + 1;
        end
        "R":
        begin
          code = $fscanf(fd, "%h %h", t_addr, t_data);
          if (code != 2)
            abort_run("malformed R line in the trace");
          idle_gap();
          apb_read(t_addr, t_data);
          n_ops = n_ops + 1;
        end
        "I":
        begin
          code = $fscanf(fd, "%d %d %h %h %h %h", t_slot, t_opc, t_ps1, t_ps2, t_pdst, t_free);
          if (code != 6)
            abort_run("malformed I line in the trace");
          e_slot     = t_slot[`SLOT_BITS-1:0];
          e_opc      = rename_pkg::opcode_e'(t_opc[1:0]);
          e_ps1      = rename_pkg::map_entry_t'(t_ps1[`MAP_ENTRY_BITS-1:0]);
          e_ps2      = rename_pkg::map_entry_t'(t_ps2[`MAP_ENTRY_BITS-1:0]);
          e_pdst     = t_pdst[`PREG_BITS-1:0];
          // free column is the valid bit over the preg index
          e_free_vld = t_free[`PREG_BITS];
          e_free_idx = t_free[`PREG_BITS-1:0];
          // a stall from the trace holds this instruction on the port first
          if (stall_n > 0)
            hold_stall(stall_n, e_slot, e_opc, e_ps1, e_ps2, e_pdst, e_free_vld, e_free_idx);
          stall_n = 0;
          expect_issue(e_slot, e_opc, e_ps1, e_ps2, e_pdst, e_free_vld, e_free_idx);
          n_ops = n_ops + 1;
        end
        "S":
        begin
          code = $fscanf(fd, "%d", t_data);
          if (code != 1)
            abort_run("malformed S line in the trace");
          stall_n = int'(t_data);
          n_ops = n_ops + 1;
        end
        default: abort_run($sformatf("unknown operation %s in the trace", op));
      endcase
    end
    $fclose(fd);

    if ((n_ops == 0) || (stall_n != 0))
    begin
      $display("trace held no operations or ended on a stall with no issue after it");
      $display("Regression failed");
      $fatal(1, "bad trace");
    end
    else
    begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verilog/rename_top.sv
// rename top: line store feeding a chain of rename lanes drained by issue select
`default_nettype none
`timescale 1ns/1ps

`include "rename_params.svh"

module rename_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  apb_pkg::apb_addr_t      paddr_i,
  input  apb_pkg::apb_data_t      pwdata_i,
  output apb_pkg::apb_data_t      prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  input  logic                    issue_rdy_i,
  output logic                    issue_vld_o,
  output logic [`SLOT_BITS-1:0]   issue_slot_o,
  output rename_pkg::opcode_e     issue_opcode_o,
  output rename_pkg::map_entry_t  issue_psrc1_o,
  output rename_pkg::map_entry_t  issue_psrc2_o,
  output rename_pkg::preg_t       issue_pdst_o,
  output rename_pkg::free_preg_t  issue_free_o
);

  logic [`ISQ_DEPTH-1:0]                   slot_vld;
  logic [`ISQ_DEPTH-1:0]                   slot_issued;
  logic [`ISQ_DEPTH-1:0]                   lane_rdy;
  logic [`ISQ_DEPTH-1:0]                   dst_rdy_en;
  logic [`ISQ_DEPTH-1:0]                   dst_rdy_val;
  logic [`ISQ_DEPTH-1:0]                   issue_onehot;
  logic                                    issue_fire;
  rename_pkg::opcode_e [`ISQ_DEPTH-1:0]    opcode;
  rename_pkg::lreg_t [`ISQ_DEPTH-1:0]      lsrc1;
  rename_pkg::lreg_t [`ISQ_DEPTH-1:0]      lsrc2;
  rename_pkg::lreg_t [`ISQ_DEPTH-1:0]      ldst;
  rename_pkg::preg_t [`ISQ_DEPTH-1:0]      pdst;
  rename_pkg::map_entry_t [`ISQ_DEPTH-1:0] psrc1;
  rename_pkg::map_entry_t [`ISQ_DEPTH-1:0] psrc2;
  rename_pkg::free_preg_t [`ISQ_DEPTH-1:0] free_preg;
  // entry 0 is the base map, entry i+1 leaves lane i
  rename_pkg::map_entry_t [`NUM_LREG-1:0]  map_chain [`ISQ_DEPTH+1];

  isq_line_store u_store (
    .clk           (clk),
    .rst_n         (rst_n),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .issue_fire_i  (issue_fire),
    .issue_slot_i  (issue_onehot),
    .lane_rdy_i    (lane_rdy),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .slot_vld_o    (slot_vld),
    .slot_issued_o (slot_issued),
    .opcode_o      (opcode),
    .lsrc1_o       (lsrc1),
    .lsrc2_o       (lsrc2),
    .ldst_o        (ldst),
    .pdst_o        (pdst),
    .base_map_o    (map_chain[0]),
    .dst_rdy_en_o  (dst_rdy_en),
    .dst_rdy_val_o (dst_rdy_val)
  );

  //////////////////////////////
  // lane chain, oldest slot first
  //////////////////////////////
  for (genvar g = 0; g < `ISQ_DEPTH; g++)
  begin : g_lane
    rename_lane u_lane (
      .clk           (clk),
      .rst_n         (rst_n),
      .slot_vld_i    (slot_vld[g]),
      .lsrc1_i       (lsrc1[g]),
      .lsrc2_i       (lsrc2[g]),
      .ldst_i        (ldst[g]),
      .pdst_i        (pdst[g]),
      .dst_rdy_en_i  (dst_rdy_en[g]),
      .dst_rdy_val_i (dst_rdy_val[g]),
      .prv_map_i     (map_chain[g]),
      .cur_map_o     (map_chain[g+1]),
      .psrc1_o       (psrc1[g]),
      .psrc2_o       (psrc2[g]),
      .inst_rdy_o    (lane_rdy[g]),
      .free_preg_o   (free_preg[g])
    );
  end

  issue_select u_select (
    .slot_vld_i     (slot_vld),
    .slot_issued_i  (slot_issued),
    .lane_rdy_i     (lane_rdy),
    .opcode_i       (opcode),
    .pdst_i         (pdst),
    .psrc1_i        (psrc1),
    .psrc2_i        (psrc2),
    .free_preg_i    (free_preg),
    .issue_rdy_i    (issue_rdy_i),
    .issue_vld_o    (issue_vld_o),
    .issue_slot_o   (issue_slot_o),
    .issue_opcode_o (issue_opcode_o),
    .issue_psrc1_o  (issue_psrc1_o),
    .issue_psrc2_o  (issue_psrc2_o),
    .issue_pdst_o   (issue_pdst_o),
    .issue_free_o   (issue_free_o),
    .issue_fire_o   (issue_fire),
    .issue_onehot_o (issue_onehot)
  );

endmodule

`default_nettype wire

// File: verilog/issue_select.sv
// issue select: picks the oldest valid, ready, unissued slot for the issue port
`default_nettype none
`timescale 1ns/1ps

`include "rename_params.svh"

module issue_select (
  input  logic [`ISQ_DEPTH-1:0]                    slot_vld_i,
  input  logic [`ISQ_DEPTH-1:0]                    slot_issued_i,
  input  logic [`ISQ_DEPTH-1:0]                    lane_rdy_i,
  input  rename_pkg::opcode_e [`ISQ_DEPTH-1:0]     opcode_i,
  input  rename_pkg::preg_t [`ISQ_DEPTH-1:0]       pdst_i,
  input  rename_pkg::map_entry_t [`ISQ_DEPTH-1:0]  psrc1_i,
  input  rename_pkg::map_entry_t [`ISQ_DEPTH-1:0]  psrc2_i,
  input  rename_pkg::free_preg_t [`ISQ_DEPTH-1:0]  free_preg_i,
  input  logic                                     issue_rdy_i,
  output logic                                     issue_vld_o,
  output logic [`SLOT_BITS-1:0]                    issue_slot_o,
  output rename_pkg::opcode_e                      issue_opcode_o,
  output rename_pkg::map_entry_t                   issue_psrc1_o,
  output rename_pkg::map_entry_t                   issue_psrc2_o,
  output rename_pkg::preg_t                        issue_pdst_o,
  output rename_pkg::free_preg_t                   issue_free_o,
  output logic                                     issue_fire_o,
  output logic [`ISQ_DEPTH-1:0]                    issue_onehot_o
);

  logic [`ISQ_DEPTH-1:0] cand;
  logic [`SLOT_BITS-1:0] sel;

  // candidates still waiting to go out
  assign cand = slot_vld_i & ~slot_issued_i & lane_rdy_i;

  // slot 0 is the oldest, so scan down and keep the last hit
  always_comb
  begin
    sel = '0;
    for (int i = `ISQ_DEPTH-1; i >= 0; i--)
    begin
      if (cand[i])
        sel = `SLOT_BITS'(i);
    end
  end

  always_comb
  begin
    issue_onehot_o      = '0;
    issue_onehot_o[sel] = |cand;
  end

  //////////////////////////////
  // issue port mux
  //////////////////////////////
  // held steady while the sink stalls, state only moves on fire
  assign issue_vld_o    = |cand;
  assign issue_slot_o   = sel;
  assign issue_opcode_o = opcode_i[sel];
  assign issue_psrc1_o  = psrc1_i[sel];
  assign issue_psrc2_o  = psrc2_i[sel];
  assign issue_pdst_o   = pdst_i[sel];
  assign issue_free_o   = free_preg_i[sel];
  assign issue_fire_o   = issue_vld_o && issue_rdy_i;

endmodule

`default_nettype wire

// File: verilog/rename_lane.sv
// rename lane: source lookup, destination ready flop and map hand-down for one slot
`default_nettype none
`timescale 1ns/1ps

`include "rename_params.svh"

module rename_lane (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    slot_vld_i,
  input  rename_pkg::lreg_t                       lsrc1_i,
  input  rename_pkg::lreg_t                       lsrc2_i,
  input  rename_pkg::lreg_t                       ldst_i,
  input  rename_pkg::preg_t                       pdst_i,
  input  logic                                    dst_rdy_en_i,
  input  logic                                    dst_rdy_val_i,
  input  rename_pkg::map_entry_t [`NUM_LREG-1:0]  prv_map_i,
  output rename_pkg::map_entry_t [`NUM_LREG-1:0]  cur_map_o,
  output rename_pkg::map_entry_t                  psrc1_o,
  output rename_pkg::map_entry_t                  psrc2_o,
  output logic                                    inst_rdy_o,
  output rename_pkg::free_preg_t                  free_preg_o
);

  logic dst_rdy_q;
  logic writes_dst;

  //////////////////////////////
  // destination ready flop
  //////////////////////////////
  // loaded low when the line is written, high on writeback
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      dst_rdy_q <= 1'b0;
    else if (dst_rdy_en_i)
      dst_rdy_q <= dst_rdy_val_i;
  end

  //////////////////////////////
  // source renaming
  //////////////////////////////
  // map from the older lane already holds every older destination
  always_comb
  begin
    psrc1_o = rename_pkg::PREG_READY_NONE;
    psrc2_o = rename_pkg::PREG_READY_NONE;
    if (slot_vld_i && lsrc1_i.vld)
      psrc1_o = prv_map_i[lsrc1_i.idx];
    if (slot_vld_i && lsrc2_i.vld)
      psrc2_o = prv_map_i[lsrc2_i.idx];
  end

  // an empty slot looks ready, select masks it by valid anyway
  assign inst_rdy_o = psrc1_o.rdy && psrc2_o.rdy;

  //////////////////////////////
  // map hand-down
  //////////////////////////////
  assign writes_dst = slot_vld_i && ldst_i.vld;

  always_comb
  begin
    cur_map_o = prv_map_i;
    // younger lanes see this slot's pdst and its ready flop
    if (writes_dst)
    begin
      cur_map_o[ldst_i.idx].rdy = dst_rdy_q;
      cur_map_o[ldst_i.idx].idx = pdst_i;
    end
  end

  // previous owner of ldst gets freed at commit
  assign free_preg_o.vld = ldst_i.vld;
  assign free_preg_o.idx = prv_map_i[ldst_i.idx].idx;

endmodule

`default_nettype wire

// File: verilog/isq_line_store.sv
// issue queue line store: apb slave for slot lines, base map, valid and issued bits
`default_nettype none
`timescale 1ns/1ps

`include "rename_params.svh"

module isq_line_store (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    psel_i,
  input  logic                                    penable_i,
  input  logic                                    pwrite_i,
  input  apb_pkg::apb_addr_t                      paddr_i,
  input  apb_pkg::apb_data_t                      pwdata_i,
  input  logic                                    issue_fire_i,
  input  logic [`ISQ_DEPTH-1:0]                   issue_slot_i,
  input  logic [`ISQ_DEPTH-1:0]                   lane_rdy_i,
  output apb_pkg::apb_data_t                      prdata_o,
  output logic                                    pready_o,
  output logic                                    pslverr_o,
  output logic [`ISQ_DEPTH-1:0]                   slot_vld_o,
  output logic [`ISQ_DEPTH-1:0]                   slot_issued_o,
  output rename_pkg::opcode_e [`ISQ_DEPTH-1:0]    opcode_o,
  output rename_pkg::lreg_t [`ISQ_DEPTH-1:0]      lsrc1_o,
  output rename_pkg::lreg_t [`ISQ_DEPTH-1:0]      lsrc2_o,
  output rename_pkg::lreg_t [`ISQ_DEPTH-1:0]      ldst_o,
  output rename_pkg::preg_t [`ISQ_DEPTH-1:0]      pdst_o,
  output rename_pkg::map_entry_t [`NUM_LREG-1:0]  base_map_o,
  output logic [`ISQ_DEPTH-1:0]                   dst_rdy_en_o,
  output logic [`ISQ_DEPTH-1:0]                   dst_rdy_val_o
);

  apb_pkg::region_e                       region;
  logic [`LREG_BITS-1:0]                  addr_idx;
  logic [`SLOT_BITS-1:0]                  data_slot;
  logic                                   access;
  logic                                   err;
  logic                                   wr_ok;
  logic                                   line_wr;
  logic                                   map_wr;
  logic                                   wb_wr;
  logic                                   retire_wr;
  apb_pkg::line_word_t                    line_word;
  apb_pkg::status_word_t                  status;
  logic [`ISQ_DEPTH-1:0]                  vld_q;
  logic [`ISQ_DEPTH-1:0]                  issued_q;
  rename_pkg::map_entry_t [`NUM_LREG-1:0] base_map_q;

  //////////////////////////////
  // apb decode
  //////////////////////////////
  assign region    = apb_pkg::region_e'(paddr_i[`APB_ADDR_BITS-1 -: 4]);
  assign addr_idx  = paddr_i[`LREG_BITS-1:0];
  // wb and retire carry the slot number in the data word
  assign data_slot = pwdata_i[`SLOT_BITS-1:0];
  assign line_word = apb_pkg::line_word_t'(pwdata_i);

  always_comb
  begin
    case (region)
      apb_pkg::REG_LINE:   err = (addr_idx >= `ISQ_DEPTH);
      apb_pkg::REG_MAP:    err = 1'b0;
      apb_pkg::REG_WB,
      apb_pkg::REG_RETIRE: err = pwrite_i && (pwdata_i >= `ISQ_DEPTH);
      // status is read only
      apb_pkg::REG_STATUS: err = pwrite_i;
      default:             err = 1'b1;
    endcase
  end

  // zero wait states, ready in every access phase
  assign access    = psel_i && penable_i;
  assign pready_o  = access;
  assign pslverr_o = access && err;
  assign wr_ok     = access && pwrite_i && !err;
  assign line_wr   = wr_ok && (region == apb_pkg::REG_LINE);
  assign map_wr    = wr_ok && (region == apb_pkg::REG_MAP);
  assign wb_wr     = wr_ok && (region == apb_pkg::REG_WB);
  assign retire_wr = wr_ok && (region == apb_pkg::REG_RETIRE);

  //////////////////////////////
  // slot state
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      vld_q    <= '0;
      issued_q <= '0;
    end
    else
    begin
      for (int i = 0; i < `ISQ_DEPTH; i++)
      begin
        // select marks the slot in the same edge it fires
        if (issue_fire_i && issue_slot_i[i])
          issued_q[i] <= 1'b1;
        // a new line overrides a same-cycle issue mark
        if (line_wr && (addr_idx == i))
        begin
          vld_q[i]    <= 1'b1;
          issued_q[i] <= 1'b0;
        end
        else if (retire_wr && (data_slot == i))
        begin
          vld_q[i]    <= 1'b0;
          issued_q[i] <= 1'b0;
        end
      end
    end
  end

  // line payload, qualified by vld_q
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < `ISQ_DEPTH; i++)
    begin
      if (line_wr && (addr_idx == i))
      begin
        opcode_o[i] <= line_word.opcode;
        lsrc1_o[i]  <= line_word.lsrc1;
        lsrc2_o[i]  <= line_word.lsrc2;
        ldst_o[i]   <= line_word.ldst;
        pdst_o[i]   <= line_word.pdst;
      end
    end
  end

  // base map starts all not ready, index 0
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      base_map_q <= '0;
    else if (map_wr)
      base_map_q[addr_idx] <= rename_pkg::map_entry_t'(pwdata_i[`MAP_ENTRY_BITS-1:0]);
  end

  // ready flop pulses: line load clears, writeback sets
  always_comb
  begin
    for (int i = 0; i < `ISQ_DEPTH; i++)
    begin
      dst_rdy_val_o[i] = wb_wr && (data_slot == i);
      dst_rdy_en_o[i]  = (line_wr && (addr_idx == i)) || dst_rdy_val_o[i];
    end
  end

  //////////////////////////////
  // status readback
  //////////////////////////////
  always_comb
  begin
    status        = '0;
    status.vld    = 8'(vld_q);
    status.issued = 8'(issued_q);
    status.rdy    = 8'(lane_rdy_i);
  end

  assign prdata_o = (psel_i && !pwrite_i && (region == apb_pkg::REG_STATUS)) ? status : '0;

  assign slot_vld_o    = vld_q;
  assign slot_issued_o = issued_q;
  assign base_map_o    = base_map_q;

endmodule

`default_nettype wire

// File: verilog/apb_pkg.sv
// apb register map types: address regions, line word and status word
`default_nettype none

package apb_pkg;

  `include "rename_params.svh"

  typedef logic [`APB_ADDR_BITS-1:0] apb_addr_t;
  typedef logic [`APB_DATA_BITS-1:0] apb_data_t;

  // top four address bits select the region
  typedef enum logic [3:0] {
    REG_LINE   = 4'h0,
    REG_MAP    = 4'h1,
    REG_WB     = 4'h2,
    REG_RETIRE = 4'h3,
    REG_STATUS = 4'h4
  } region_e;

  // slot line as written by the host, msb first
  typedef struct packed {
    logic [8:0]          rsvd;
    rename_pkg::preg_t   pdst;
    rename_pkg::lreg_t   ldst;
    rename_pkg::lreg_t   lsrc2;
    rename_pkg::lreg_t   lsrc1;
    rename_pkg::opcode_e opcode;
  } line_word_t;

  // status read, one bitmap per byte
  typedef struct packed {
    logic [7:0] rsvd;
    logic [7:0] rdy;
    logic [7:0] issued;
    logic [7:0] vld;
  } status_word_t;

endpackage

`default_nettype wire

// File: verilog/rename_pkg.sv
// rename types shared by the lanes, the line store and the issue port
`default_nettype none

package rename_pkg;

  `include "rename_params.svh"

  // instruction class, carried unchanged to the issue port
  typedef enum logic [1:0] {
    ALU    = 2'd0,
    LOAD   = 2'd1,
    STORE  = 2'd2,
    BRANCH = 2'd3
  } opcode_e;

  // logical register with its valid bit on top
  typedef struct packed {
    logic                  vld;
    logic [`LREG_BITS-1:0] idx;
  } lreg_t;

  typedef logic [`PREG_BITS-1:0] preg_t;

  // one map entry: ready bit over the physical index
  typedef struct packed {
    logic  rdy;
    preg_t idx;
  } map_entry_t;

  // register to free once the slot commits, vld clear when nothing is freed
  typedef struct packed {
    logic  vld;
    preg_t idx;
  } free_preg_t;

  // absent sources read as ready, index 0
  localparam map_entry_t PREG_READY_NONE = map_entry_t'(`MAP_ENTRY_BITS'h40);

endpackage

`default_nettype wire

// File: include/rename_params.svh
// rename issue queue parameters for depth, register counts and apb widths
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// queue slots, one rename lane per slot
`define ISQ_DEPTH 4
// bits needed to name a slot
`define SLOT_BITS 2

// logical register file
`define NUM_LREG 16
`define LREG_BITS 4

// physical register index width
`define PREG_BITS 6
// ready bit on top of the physical index
`define MAP_ENTRY_BITS 7

// apb bus
`define APB_ADDR_BITS 8
`define APB_DATA_BITS 32

`endif
